/* build.f */
src/core_bus_pkg.sv
src/rv_isa_pkg.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_exec.sv
src/wb_arbiter.sv
src/rv_core_top.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module rv_core_tb -o rv_core_sim

# the simulator may exit non-zero on failure, the log decides
./obj_dir/rv_core_sim | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

/* dv/rv_core_tb.sv */
// testbench for the rv32i core
// wishbone memory model with random wait states, small assembler helpers
// and directed programs that end in ecall, results checked in memory
`default_nettype none

module rv_core_tb import core_bus_pkg::*, rv_isa_pkg::*; ();

	localparam int num_tests = 5;
	localparam int test_cycles = 2000;
	localparam int reset_cycles = 16;
	localparam int halt_hold = 50;
	// result slots at byte 0x400 and source data at 0x600
	localparam int result_word = 256;
	localparam int source_word = 384;

	logic clock, reset, wb_ack;
	logic [xlen-1:0] wb_rdat;
	logic o_wb_cyc, o_wb_stb, o_wb_we, o_halted;
	logic [adr_w-1:0] o_wb_adr;
	logic [xlen-1:0] o_wb_dat;
	logic [sel_w-1:0] o_wb_sel;

	logic [xlen-1:0] mem [0:1023];
	logic [xlen-1:0] expect_q [$];
	logic [31:0] rng_state;
	logic pending;
	logic [1:0] wait_left;
	int prog_ptr;

	rv_core_top i_rv_core_top (
		.clock(clock), .reset(reset),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
		.o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel), .i_wb_dat(wb_rdat), .i_wb_ack(wb_ack),
		.o_halted(o_halted)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// lcg with numerical recipes constants
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	// memory slave acks after 0 to 3 wait cycles for one cycle
	always @(posedge clock) begin
		logic [31:0] rnd;
		#2;
		if (reset || wb_ack) begin
			wb_ack = 1'b0;
			pending = 1'b0;
		end else if (o_wb_cyc && o_wb_stb) begin
			if (!pending) begin
				rnd = lcg_next();
				wait_left = rnd[17:16];
				pending = 1'b1;
			end
			if (wait_left == 2'd0) begin
				// every access is a full word
				check_value("wb_sel", 32'hf, {{(32-sel_w){1'b0}}, o_wb_sel});
				if (o_wb_we) begin
					mem[o_wb_adr[11:2]] = o_wb_dat;
				end else begin
					wb_rdat = mem[o_wb_adr[11:2]];
				end
				wb_ack = 1'b1;
				pending = 1'b0;
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

	// instruction encoders
	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	// rv32i branch conditions by funct3
	function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	// reset held while the next program is written
	task automatic hold_reset();
		step();
		reset = 1'b1;
		for (int k = 0; k < 1024; k++) begin
			mem[k] = 32'hc0de_0000 | k;
		end
		expect_q.delete();
		prog_ptr = 0;
	endtask

	task automatic release_reset();
		repeat (reset_cycles) step();
		reset = 1'b0;
	endtask

	function automatic logic [31:0] cur_pc();
		return prog_ptr * 4;
	endfunction

	task automatic put_instr(input logic [31:0] w);
		mem[prog_ptr] = w;
		prog_ptr++;
	endtask

	// sw x3 to the next result slot off x10
	task automatic store_result(input logic [31:0] exp);
		put_instr(stype_word(12'(expect_q.size() * 4), 5'd3, 5'd10));
		expect_q.push_back(exp);
	endtask

	task automatic add_result_op(input logic [31:0] w, input logic [31:0] exp);
		put_instr(w);
		store_result(exp);
	endtask

	// x10 = result base, x1 = -20, x2 = 0x12345678
	task automatic common_setup();
		put_instr(itype_word(12'h400, 5'd0, 3'b000, 5'd10, opc_op_imm));
		put_instr(itype_word(12'hfec, 5'd0, 3'b000, 5'd1, opc_op_imm));
		put_instr(utype_word(20'h12345, 5'd2, opc_lui));
		put_instr(itype_word(12'h678, 5'd2, 3'b000, 5'd2, opc_op_imm));
	endtask

	task automatic run_until_halt(input string name);
		int n;
		put_instr(32'h0000_0073);
		release_reset();
		n = 0;
		while (!o_halted && n < test_cycles) begin
			step();
			n++;
		end
		if (!o_halted) begin
			$display("%s: core did not reach ecall in time", name);
			$display("Errors found");
			$fatal(1, "halt timeout");
		end
		for (int k = 0; k < expect_q.size(); k++) begin
			check_value(name, expect_q[k], mem[result_word + k]);
		end
	endtask

	task automatic arith_test();
		logic [31:0] a, b;
		a = 32'hffff_ffec;
		b = 32'h1234_5678;
		hold_reset();
		common_setup();
		// shift amount 35 checks that only rs2[4:0] is used
		put_instr(itype_word(12'd35, 5'd0, 3'b000, 5'd4, opc_op_imm));
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
		add_result_op(rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
		add_result_op(rtype_word(7'h00, 5'd4, 5'd2, 3'b001, 5'd3), b << 3);
		add_result_op(rtype_word(7'h00, 5'd4, 5'd1, 3'b101, 5'd3), a >> 3);
		add_result_op(rtype_word(7'h20, 5'd4, 5'd1, 3'b101, 5'd3), 32'($signed(a) >>> 3));
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd3),
			($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		add_result_op(rtype_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), (a < b) ? 32'd1 : 32'd0);
		add_result_op(itype_word(12'd100, 5'd1, 3'b000, 5'd3, opc_op_imm), a + 32'd100);
		add_result_op(itype_word(12'hffb, 5'd1, 3'b010, 5'd3, opc_op_imm),
			($signed(a) < -5) ? 32'd1 : 32'd0);
		add_result_op(itype_word(12'd5, 5'd1, 3'b011, 5'd3, opc_op_imm),
			(a < 32'd5) ? 32'd1 : 32'd0);
		add_result_op(itype_word(12'hfff, 5'd2, 3'b100, 5'd3, opc_op_imm), ~b);
		add_result_op(itype_word(12'h0f0, 5'd1, 3'b110, 5'd3, opc_op_imm), a | 32'h0f0);
		add_result_op(itype_word(12'h7ff, 5'd2, 3'b111, 5'd3, opc_op_imm), b & 32'h7ff);
		add_result_op(itype_word(12'd4, 5'd2, 3'b001, 5'd3, opc_op_imm), b << 4);
		add_result_op(itype_word(12'd28, 5'd1, 3'b101, 5'd3, opc_op_imm), a >> 28);
		add_result_op(itype_word(12'h402, 5'd1, 3'b101, 5'd3, opc_op_imm),
			32'($signed(a) >>> 2));
		run_until_halt("arith");
	endtask

	task automatic upper_imm_test();
		hold_reset();
		common_setup();
		add_result_op(utype_word(20'habcde, 5'd3, opc_lui), 32'habcd_e000);
		add_result_op(utype_word(20'hfffff, 5'd3, opc_lui), 32'hffff_f000);
		add_result_op(utype_word(20'h00012, 5'd3, opc_auipc), 32'h0001_2000 + cur_pc());
		add_result_op(utype_word(20'h80000, 5'd3, opc_auipc), 32'h8000_0000 + cur_pc());
		run_until_halt("upper_imm");
	endtask

	// marker 1 when the branch skips the second addi, 2 when it falls through
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] av, input logic [31:0] bv);
		put_instr(itype_word(12'd1, 5'd0, 3'b000, 5'd3, opc_op_imm));
		put_instr(btype_word(13'd8, rs2, rs1, f3));
		put_instr(itype_word(12'd2, 5'd0, 3'b000, 5'd3, opc_op_imm));
		store_result(branch_rule(f3, av, bv) ? 32'd1 : 32'd2);
	endtask

	task automatic branch_pairs(input logic [2:0] f3);
		branch_case(f3, 5'd1, 5'd2, 32'hffff_ffec, 32'h1234_5678);
		branch_case(f3, 5'd2, 5'd1, 32'h1234_5678, 32'hffff_ffec);
		branch_case(f3, 5'd2, 5'd2, 32'h1234_5678, 32'h1234_5678);
	endtask

	task automatic branch_test();
		logic [31:0] sum, link_pc;
		sum = 0;
		for (int k = 1; k <= 10; k++) begin
			sum = sum + k;
		end
		hold_reset();
		common_setup();
		// x5 accumulates x6 counting down from 10
		put_instr(itype_word(12'd0, 5'd0, 3'b000, 5'd5, opc_op_imm));
		put_instr(itype_word(12'd10, 5'd0, 3'b000, 5'd6, opc_op_imm));
		put_instr(rtype_word(7'h00, 5'd6, 5'd5, 3'b000, 5'd5));
		put_instr(itype_word(12'hfff, 5'd6, 3'b000, 5'd6, opc_op_imm));
		put_instr(btype_word(13'h1ff8, 5'd0, 5'd6, 3'b001));
		add_result_op(rtype_word(7'h00, 5'd0, 5'd5, 3'b000, 5'd3), sum);
		branch_pairs(3'b000);
		branch_pairs(3'b001);
		branch_pairs(3'b100);
		branch_pairs(3'b101);
		branch_pairs(3'b110);
		branch_pairs(3'b111);
		// jal over one instruction with the link in x9
		put_instr(itype_word(12'd1, 5'd0, 3'b000, 5'd3, opc_op_imm));
		link_pc = cur_pc();
		put_instr(jtype_word(21'd8, 5'd9));
		put_instr(itype_word(12'd7, 5'd0, 3'b000, 5'd3, opc_op_imm));
		store_result(32'd1);
		add_result_op(rtype_word(7'h00, 5'd0, 5'd9, 3'b000, 5'd3), link_pc + 4);
		// jalr to an odd address drops bit 0
		put_instr(itype_word(12'd1, 5'd0, 3'b000, 5'd3, opc_op_imm));
		link_pc = cur_pc();
		put_instr(itype_word(12'(link_pc + 13), 5'd0, 3'b000, 5'd11, opc_op_imm));
		put_instr(itype_word(12'd0, 5'd11, 3'b000, 5'd12, opc_jalr));
		put_instr(itype_word(12'd9, 5'd0, 3'b000, 5'd3, opc_op_imm));
		store_result(32'd1);
		add_result_op(rtype_word(7'h00, 5'd0, 5'd12, 3'b000, 5'd3), link_pc + 8);
		run_until_halt("branch");
	endtask

	task automatic load_store_test();
		logic [31:0] src [0:3];
		hold_reset();
		common_setup();
		put_instr(itype_word(12'h600, 5'd0, 3'b000, 5'd13, opc_op_imm));
		for (int k = 0; k < 4; k++) begin
			src[k] = lcg_next();
			mem[source_word + k] = src[k];
			put_instr(itype_word(12'(k * 4), 5'd13, 3'b010, 5'd3, opc_load));
			add_result_op(itype_word(12'd1, 5'd3, 3'b000, 5'd3, opc_op_imm), src[k] + 1);
		end
		// write to x0 has no effect
		put_instr(itype_word(12'd123, 5'd0, 3'b000, 5'd0, opc_op_imm));
		add_result_op(rtype_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), 32'd0);
		run_until_halt("load_store");
	endtask

	task automatic halt_reset_test();
		int n;
		hold_reset();
		common_setup();
		add_result_op(itype_word(12'd5, 5'd0, 3'b000, 5'd3, opc_op_imm), 32'd5);
		run_until_halt("halt");
		repeat (halt_hold) begin
			step();
			check_value("halt_stays", 32'd1, {31'd0, o_halted});
			check_value("halt_no_bus", 32'd0, {31'd0, o_wb_cyc});
		end
		hold_reset();
		common_setup();
		release_reset();
		check_value("reset_halted", 32'd0, {31'd0, o_halted});
		n = 0;
		while (!o_wb_cyc && n < test_cycles) begin
			step();
			n++;
		end
		check_value("reset_first_cyc", 32'd1, {31'd0, o_wb_cyc});
		check_value("reset_first_adr", reset_pc, o_wb_adr);
	endtask

	initial begin
		int limit;
		// the halt test resets twice
		limit = (num_tests + 1) * (test_cycles + reset_cycles + 1) + halt_hold;
		repeat (limit) @(posedge clock);
		$display("watchdog: simulation ran past its cycle budget");
		$display("Errors found");
		$fatal(1, "watchdog");
	end

	initial begin
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_rdat = '0;
		pending = 1'b0;
		wait_left = 2'd0;
		rng_state = 32'd44961;
		prog_ptr = 0;
		arith_test();
		upper_imm_test();
		branch_test();
		load_store_test();
		halt_reset_test();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/rv_core_properties.sv */
// wishbone and halt properties for the core top
// attached to rv_core_top by bind
`default_nettype none

module rv_core_properties (
	input wire        clock,
	input wire        reset,
	input wire        i_wb_cyc,
	input wire        i_wb_stb,
	input wire        i_wb_we,
	input wire [31:0] i_wb_adr,
	input wire        i_wb_ack,
	input wire        i_halted
);

	// strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		i_wb_stb |-> i_wb_cyc) else $error("stb high without cyc");

	// request held until ack
	req_stable: assert property (@(posedge clock) disable iff (reset)
		(i_wb_stb && !i_wb_ack) |=> ($stable(i_wb_adr) && $stable(i_wb_we)))
		else $error("address or we changed before ack");

	// halted core stays off the bus
	halt_quiet: assert property (@(posedge clock) disable iff (reset)
		i_halted |-> !i_wb_cyc) else $error("bus cycle while halted");

endmodule

bind rv_core_top rv_core_properties i_rv_core_properties (
	.clock(clock), .reset(reset),
	.i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb), .i_wb_we(o_wb_we),
	.i_wb_adr(o_wb_adr), .i_wb_ack(i_wb_ack), .i_halted(o_halted)
);

`default_nettype wire

/* src/rv_core_top.sv */
// rv32i multi-cycle core
// fetch, decode, register file and execute sharing one wishbone port
`default_nettype none

module rv_core_top import core_bus_pkg::*, rv_isa_pkg::*; (
	input  wire              clock,
	input  wire              reset,
	output logic             o_wb_cyc,
	output logic             o_wb_stb,
	output logic             o_wb_we,
	output logic [adr_w-1:0] o_wb_adr,
	output logic [xlen-1:0]  o_wb_dat,
	output logic [sel_w-1:0] o_wb_sel,
	input  wire [xlen-1:0]   i_wb_dat,
	input  wire              i_wb_ack,
	output logic             o_halted
);

	// fetch to decode
	logic f_valid, d_ready;
	logic [xlen-1:0] f_instr;
	logic [adr_w-1:0] f_pc;

	// register file
	logic [reg_addr_w-1:0] ra_addr, rb_addr, wr_addr;
	logic [xlen-1:0] ra_data, rb_data, wr_data;
	logic we;

	// decode to execute
	logic d_valid, x_ready;
	logic [xlen-1:0] op_a, op_b, op_c;
	logic [alu_op_w-1:0] alu_op;
	logic [op_type_w-1:0] op_type;
	logic [reg_addr_w-1:0] rd_addr;
	logic [2:0] cond;

	// execute back to fetch
	logic redirect;
	logic [adr_w-1:0] redirect_pc;

	// arbiter ports, fetch is master 0
	logic f_cyc, f_stb, f_ack;
	logic [adr_w-1:0] f_adr;
	logic [xlen-1:0] f_dat;
	logic x_cyc, x_stb, x_we, x_ack;
	logic [adr_w-1:0] x_adr;
	logic [xlen-1:0] x_wdat, x_rdat;
	logic [sel_w-1:0] x_sel;

	rv_fetch u_fetch (
		.clock(clock), .reset(reset),
		.i_redirect(redirect), .i_redirect_pc(redirect_pc),
		.o_valid(f_valid), .i_ready(d_ready), .o_instr(f_instr), .o_pc(f_pc),
		.o_wb_cyc(f_cyc), .o_wb_stb(f_stb), .o_wb_adr(f_adr),
		.i_wb_dat(f_dat), .i_wb_ack(f_ack)
	);

	rv_decode u_decode (
		.clock(clock), .reset(reset),
		.i_valid(f_valid), .i_instr(f_instr), .i_pc(f_pc), .o_ready(d_ready),
		.o_ra_addr(ra_addr), .o_rb_addr(rb_addr), .i_ra_data(ra_data), .i_rb_data(rb_data),
		.o_valid(d_valid), .i_ready(x_ready),
		.o_op_a(op_a), .o_op_b(op_b), .o_op_c(op_c), .o_alu_op(alu_op),
		.o_op_type(op_type), .o_rd_addr(rd_addr), .o_cond(cond)
	);

	rv_regfile u_regfile (
		.clock(clock),
		.i_ra_addr(ra_addr), .i_rb_addr(rb_addr), .o_ra_data(ra_data), .o_rb_data(rb_data),
		.i_we(we), .i_wr_addr(wr_addr), .i_wr_data(wr_data)
	);

	// exec takes the fetched pc directly, it holds until redirect
	rv_exec u_exec (
		.clock(clock), .reset(reset),
		.i_valid(d_valid), .o_ready(x_ready),
		.i_op_a(op_a), .i_op_b(op_b), .i_op_c(op_c), .i_alu_op(alu_op),
		.i_op_type(op_type), .i_rd_addr(rd_addr), .i_cond(cond), .i_pc(f_pc),
		.o_we(we), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
		.o_redirect(redirect), .o_redirect_pc(redirect_pc), .o_halted(o_halted),
		.o_wb_cyc(x_cyc), .o_wb_stb(x_stb), .o_wb_we(x_we), .o_wb_adr(x_adr),
		.o_wb_dat(x_wdat), .o_wb_sel(x_sel), .i_wb_dat(x_rdat), .i_wb_ack(x_ack)
	);

	// fetch only reads full words
	wb_arbiter u_arbiter (
		.clock(clock), .reset(reset),
		.i_m0_cyc(f_cyc), .i_m0_stb(f_stb), .i_m0_we(1'b0), .i_m0_adr(f_adr),
		.i_m0_dat({xlen{1'b0}}), .i_m0_sel({sel_w{1'b1}}),
		.o_m0_ack(f_ack), .o_m0_dat(f_dat),
		.i_m1_cyc(x_cyc), .i_m1_stb(x_stb), .i_m1_we(x_we), .i_m1_adr(x_adr),
		.i_m1_dat(x_wdat), .i_m1_sel(x_sel),
		.o_m1_ack(x_ack), .o_m1_dat(x_rdat),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
		.o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
	);

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
// two-master wishbone classic arbiter
// round-robin grant, held while the granted master keeps cyc high
`default_nettype none

module wb_arbiter import core_bus_pkg::*; (
	input  wire              clock,
	input  wire              reset,
	input  wire              i_m0_cyc,
	input  wire              i_m0_stb,
	input  wire              i_m0_we,
	input  wire [adr_w-1:0]  i_m0_adr,
	input  wire [xlen-1:0]   i_m0_dat,
	input  wire [sel_w-1:0]  i_m0_sel,
	output logic             o_m0_ack,
	output logic [xlen-1:0]  o_m0_dat,
	input  wire              i_m1_cyc,
	input  wire              i_m1_stb,
	input  wire              i_m1_we,
	input  wire [adr_w-1:0]  i_m1_adr,
	input  wire [xlen-1:0]   i_m1_dat,
	input  wire [sel_w-1:0]  i_m1_sel,
	output logic             o_m1_ack,
	output logic [xlen-1:0]  o_m1_dat,
	output logic             o_wb_cyc,
	output logic             o_wb_stb,
	output logic             o_wb_we,
	output logic [adr_w-1:0] o_wb_adr,
	output logic [xlen-1:0]  o_wb_dat,
	output logic [sel_w-1:0] o_wb_sel,
	input  wire [xlen-1:0]   i_wb_dat,
	input  wire              i_wb_ack
);

	// locked: a grant is held, last: master served most recently
	logic locked, last, sel, held;

	assign held = locked && (last ? i_m1_cyc : i_m0_cyc);

	// new grant in the same cycle cyc is first seen
	always_comb begin
		if (held) begin
			sel = last;
		end else if (i_m0_cyc && i_m1_cyc) begin
			sel = ~last;
		end else begin
			sel = i_m1_cyc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			locked <= 1'b0;
			// fetch wins the first tie
			last <= 1'b1;
		end else begin
			locked <= o_wb_cyc;
			if (o_wb_cyc) begin
				last <= sel;
			end
		end
	end

	// request mux
	assign o_wb_cyc = sel ? i_m1_cyc : i_m0_cyc;
	assign o_wb_stb = sel ? i_m1_stb : i_m0_stb;
	assign o_wb_we = sel ? i_m1_we : i_m0_we;
	assign o_wb_adr = sel ? i_m1_adr : i_m0_adr;
	assign o_wb_dat = sel ? i_m1_dat : i_m0_dat;
	assign o_wb_sel = sel ? i_m1_sel : i_m0_sel;

	// only the granted master sees ack and data
	assign o_m0_ack = i_wb_ack && !sel;
	assign o_m1_ack = i_wb_ack && sel;
	assign o_m0_dat = sel ? '0 : i_wb_dat;
	assign o_m1_dat = sel ? i_wb_dat : '0;

endmodule

`default_nettype wire

/* src/rv_exec.sv */
// execute unit
// alu, branch resolution, next pc, word load/store over wishbone,
// register write-back and halt on ecall
`default_nettype none

module rv_exec import core_bus_pkg::*, rv_isa_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   i_valid,
	output logic                  o_ready,
	input  wire [xlen-1:0]        i_op_a,
	input  wire [xlen-1:0]        i_op_b,
	input  wire [xlen-1:0]        i_op_c,
	input  wire [alu_op_w-1:0]    i_alu_op,
	input  wire [op_type_w-1:0]   i_op_type,
	input  wire [reg_addr_w-1:0]  i_rd_addr,
	input  wire [2:0]             i_cond,
	input  wire [adr_w-1:0]       i_pc,
	output logic                  o_we,
	output logic [reg_addr_w-1:0] o_wr_addr,
	output logic [xlen-1:0]       o_wr_data,
	output logic                  o_redirect,
	output logic [adr_w-1:0]      o_redirect_pc,
	output logic                  o_halted,
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic                  o_wb_we,
	output logic [adr_w-1:0]      o_wb_adr,
	output logic [xlen-1:0]       o_wb_dat,
	output logic [sel_w-1:0]      o_wb_sel,
	input  wire [xlen-1:0]        i_wb_dat,
	input  wire                   i_wb_ack
);

	typedef enum logic [2:0] {st_idle, st_exec, st_mem, st_wb, st_halt} exec_state_t;
	exec_state_t state;

	logic [xlen-1:0] alu_res, ld_data;
	logic [adr_w-1:0] pc_plus4;
	logic taken;

	always_comb begin
		case (i_alu_op)
			alu_sub: alu_res = i_op_a - i_op_b;
			alu_sll: alu_res = i_op_a << i_op_b[4:0];
			alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(i_op_a) < $signed(i_op_b)};
			alu_sltu: alu_res = {{(xlen-1){1'b0}}, i_op_a < i_op_b};
			alu_xor: alu_res = i_op_a ^ i_op_b;
			alu_srl: alu_res = i_op_a >> i_op_b[4:0];
			alu_sra: alu_res = $signed(i_op_a) >>> i_op_b[4:0];
			alu_or: alu_res = i_op_a | i_op_b;
			alu_and: alu_res = i_op_a & i_op_b;
			alu_eq: alu_res = {{(xlen-1){1'b0}}, i_op_a == i_op_b};
			default: alu_res = i_op_a + i_op_b;
		endcase
	end

	// bne, bge, bgeu invert the base compare
	assign taken = alu_res[0] ^ i_cond[0];
	assign pc_plus4 = i_pc + 4;

	always_comb begin
		case (i_op_type)
			op_type_branch: o_redirect_pc = taken ? i_pc + i_op_c : pc_plus4;
			// jal and jalr both add in the alu, bit 0 cleared
			op_type_jump: o_redirect_pc = {alu_res[adr_w-1:1], 1'b0};
			default: o_redirect_pc = pc_plus4;
		endcase
	end

	// write-back, rd is already zero for non-writers
	assign o_wr_addr = i_rd_addr;
	assign o_wr_data = (i_op_type == op_type_jump) ? pc_plus4 :
		(i_op_type == op_type_ld) ? ld_data : alu_res;
	assign o_we = (state == st_exec) || (state == st_wb);
	assign o_redirect = (state == st_exec) || (state == st_wb);
	assign o_ready = (state == st_idle);
	assign o_halted = (state == st_halt);

	// word accesses only
	assign o_wb_stb = o_wb_cyc;
	assign o_wb_adr = alu_res;
	assign o_wb_dat = i_op_c;
	assign o_wb_sel = {sel_w{1'b1}};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			o_wb_cyc <= 1'b0;
			o_wb_we <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (i_valid) begin
						if (i_op_type == op_type_ld || i_op_type == op_type_st) begin
							o_wb_cyc <= 1'b1;
							o_wb_we <= (i_op_type == op_type_st);
							state <= st_mem;
						end else if (i_op_type == op_type_call) begin
							state <= st_halt;
						end else begin
							state <= st_exec;
						end
					end
				end
				st_mem: begin
					if (i_wb_ack) begin
						o_wb_cyc <= 1'b0;
						o_wb_we <= 1'b0;
						state <= st_wb;
					end
				end
				// stays halted until reset
				st_halt: state <= st_halt;
				default: state <= st_idle;
			endcase
		end
	end

	// load data capture
	always_ff @(posedge clock) begin
		if (state == st_mem && i_wb_ack) begin
			ld_data <= i_wb_dat;
		end
	end

endmodule

`default_nettype wire

/* src/rv_decode.sv */
// instruction decode stage
// classifies the fetched word, builds immediates, reads rs1/rs2 and
// registers operands, alu op, op type and rd for execute
`default_nettype none

module rv_decode import core_bus_pkg::*, rv_isa_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   i_valid,
	input  wire [xlen-1:0]        i_instr,
	input  wire [adr_w-1:0]       i_pc,
	output logic                  o_ready,
	output logic [reg_addr_w-1:0] o_ra_addr,
	output logic [reg_addr_w-1:0] o_rb_addr,
	input  wire [xlen-1:0]        i_ra_data,
	input  wire [xlen-1:0]        i_rb_data,
	output logic                  o_valid,
	input  wire                   i_ready,
	output logic [xlen-1:0]       o_op_a,
	output logic [xlen-1:0]       o_op_b,
	output logic [xlen-1:0]       o_op_c,
	output logic [alu_op_w-1:0]   o_alu_op,
	output logic [op_type_w-1:0]  o_op_type,
	output logic [reg_addr_w-1:0] o_rd_addr,
	output logic [2:0]            o_cond
);

	typedef enum logic {st_decode, st_hold} decode_state_t;
	decode_state_t state;

	// instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];

	// sign-extended immediates per format
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'h000};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// rs1 and rs2 sit at fixed positions in every format
	assign o_ra_addr = i_instr[19:15];
	assign o_rb_addr = i_instr[24:20];
	assign o_ready = (state == st_decode);

	logic [xlen-1:0] op_a_d, op_b_d, op_c_d;
	logic [alu_op_w-1:0] alu_op_d, alu_fn;
	logic [op_type_w-1:0] op_type_d;
	logic [reg_addr_w-1:0] rd_d;

	// funct3 to alu select with bit 30 picking sub/sra
	always_comb begin
		case (funct3)
			3'b000: alu_fn = (opcode == opc_op && i_instr[30]) ? alu_sub : alu_add;
			3'b001: alu_fn = alu_sll;
			3'b010: alu_fn = alu_slt;
			3'b011: alu_fn = alu_sltu;
			3'b100: alu_fn = alu_xor;
			3'b101: alu_fn = i_instr[30] ? alu_sra : alu_srl;
			3'b110: alu_fn = alu_or;
			default: alu_fn = alu_and;
		endcase
	end

	always_comb begin
		// defaults give a no-op
		op_a_d = i_ra_data;
		op_b_d = imm_i;
		op_c_d = '0;
		alu_op_d = alu_add;
		op_type_d = op_type_nop;
		rd_d = '0;
		case (opcode)
			opc_lui: begin
				op_a_d = '0;
				op_b_d = imm_u;
				op_type_d = op_type_arith;
				rd_d = i_instr[11:7];
			end
			opc_auipc: begin
				op_a_d = i_pc;
				op_b_d = imm_u;
				op_type_d = op_type_arith;
				rd_d = i_instr[11:7];
			end
			opc_op_imm: begin
				// shifts take the 5-bit shamt
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					op_b_d = {{(xlen-5){1'b0}}, i_instr[24:20]};
				end
				alu_op_d = alu_fn;
				op_type_d = op_type_arith;
				rd_d = i_instr[11:7];
			end
			opc_op: begin
				op_b_d = i_rb_data;
				alu_op_d = alu_fn;
				op_type_d = op_type_arith;
				rd_d = i_instr[11:7];
			end
			opc_load: begin
				op_type_d = op_type_ld;
				rd_d = i_instr[11:7];
			end
			opc_store: begin
				// address in the alu and data rides in op_c
				op_b_d = imm_s;
				op_c_d = i_rb_data;
				op_type_d = op_type_st;
			end
			opc_branch: begin
				op_b_d = i_rb_data;
				op_c_d = imm_b;
				op_type_d = op_type_branch;
				// funct3[0] inverts the compare in execute
				case (funct3[2:1])
					2'b00: alu_op_d = alu_eq;
					2'b10: alu_op_d = alu_slt;
					default: alu_op_d = alu_sltu;
				endcase
			end
			opc_jal: begin
				// target is pc + offset through the alu
				op_a_d = i_pc;
				op_b_d = imm_j;
				op_c_d = imm_j;
				op_type_d = op_type_jump;
				rd_d = i_instr[11:7];
			end
			opc_jalr: begin
				op_type_d = op_type_jump;
				rd_d = i_instr[11:7];
			end
			opc_system: begin
				// only ecall halts and the rest is ignored
				if (funct3 == 3'b000 && i_instr[31:20] == 12'h000) begin
					op_type_d = op_type_call;
				end
			end
			default: ;
		endcase
	end

	// decode, then hold until execute takes it
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_decode;
			o_valid <= 1'b0;
		end else begin
			case (state)
				st_decode: begin
					if (i_valid) begin
						state <= st_hold;
						o_valid <= 1'b1;
					end
				end
				default: begin
					if (i_ready) begin
						state <= st_decode;
						o_valid <= 1'b0;
					end
				end
			endcase
		end
	end

	// operand registers load when fetch hands over a word
	always_ff @(posedge clock) begin
		if (i_valid && o_ready) begin
			o_op_a <= op_a_d;
			o_op_b <= op_b_d;
			o_op_c <= op_c_d;
			o_alu_op <= alu_op_d;
			o_op_type <= op_type_d;
			o_rd_addr <= rd_d;
			o_cond <= funct3;
		end
	end

endmodule

`default_nettype wire

/* src/rv_fetch.sv */
// instruction fetch
// reads one word at the current pc over wishbone and offers it to decode
`default_nettype none

module rv_fetch import core_bus_pkg::*; (
	input  wire             clock,
	input  wire             reset,
	input  wire             i_redirect,
	input  wire [adr_w-1:0] i_redirect_pc,
	output logic            o_valid,
	input  wire             i_ready,
	output logic [xlen-1:0] o_instr,
	output logic [adr_w-1:0] o_pc,
	output logic            o_wb_cyc,
	output logic            o_wb_stb,
	output logic [adr_w-1:0] o_wb_adr,
	input  wire [xlen-1:0]  i_wb_dat,
	input  wire             i_wb_ack
);

	typedef enum logic [1:0] {st_read, st_present, st_wait} fetch_state_t;
	fetch_state_t state;

	// read only with one request at a time
	assign o_wb_stb = o_wb_cyc;
	assign o_wb_adr = o_pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_read;
			o_pc <= reset_pc;
			o_valid <= 1'b0;
			o_wb_cyc <= 1'b0;
		end else begin
			case (state)
				st_read: begin
					if (o_wb_cyc && i_wb_ack) begin
						// drop the cycle right after ack
						o_wb_cyc <= 1'b0;
						o_valid <= 1'b1;
						state <= st_present;
					end else begin
						// first read after reset starts here
						o_wb_cyc <= 1'b1;
					end
				end
				st_present: begin
					if (i_ready) begin
						o_valid <= 1'b0;
						state <= st_wait;
					end
				end
				default: begin
					// execute decides the next pc
					if (i_redirect) begin
						o_pc <= i_redirect_pc;
						o_wb_cyc <= 1'b1;
						state <= st_read;
					end
				end
			endcase
		end
	end

	// instruction word captured on ack
	always_ff @(posedge clock) begin
		if (o_wb_cyc && i_wb_ack) begin
			o_instr <= i_wb_dat;
		end
	end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
// integer register file
// 32 x xlen, two asynchronous read ports, one write port, x0 reads zero
`default_nettype none

module rv_regfile import core_bus_pkg::*; (
	input  wire                   clock,
	input  wire [reg_addr_w-1:0]  i_ra_addr,
	input  wire [reg_addr_w-1:0]  i_rb_addr,
	output logic [xlen-1:0]       o_ra_data,
	output logic [xlen-1:0]       o_rb_data,
	input  wire                   i_we,
	input  wire [reg_addr_w-1:0]  i_wr_addr,
	input  wire [xlen-1:0]        i_wr_data
);

	logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

	// x0 never written
	always_ff @(posedge clock) begin
		if (i_we && i_wr_addr != '0) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// x0 forced to zero on read
	assign o_ra_data = (i_ra_addr == '0) ? '0 : regs[i_ra_addr];
	assign o_rb_data = (i_rb_addr == '0) ? '0 : regs[i_rb_addr];

endmodule

`default_nettype wire

/* src/rv_isa_pkg.sv */
// rv32i instruction set constants
// major opcodes, operation classes and alu selects shared by decode and execute
`default_nettype none

package rv_isa_pkg;

	// major opcodes, instr[6:0]
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;

	// operation class handed from decode to execute
	localparam int op_type_w = 3;
	localparam logic [op_type_w-1:0] op_type_arith  = 3'd0;
	localparam logic [op_type_w-1:0] op_type_ld     = 3'd1;
	localparam logic [op_type_w-1:0] op_type_st     = 3'd2;
	localparam logic [op_type_w-1:0] op_type_branch = 3'd3;
	localparam logic [op_type_w-1:0] op_type_jump   = 3'd4;
	localparam logic [op_type_w-1:0] op_type_call   = 3'd5;
	// anything not supported runs as a plain pc+4
	localparam logic [op_type_w-1:0] op_type_nop    = 3'd6;

	// alu selects
	localparam int alu_op_w = 4;
	localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
	localparam logic [alu_op_w-1:0] alu_sll  = 4'd2;
	localparam logic [alu_op_w-1:0] alu_slt  = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
	localparam logic [alu_op_w-1:0] alu_xor  = 4'd5;
	localparam logic [alu_op_w-1:0] alu_srl  = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sra  = 4'd7;
	localparam logic [alu_op_w-1:0] alu_or   = 4'd8;
	localparam logic [alu_op_w-1:0] alu_and  = 4'd9;
	// equality compare, used by beq/bne
	localparam logic [alu_op_w-1:0] alu_eq   = 4'd10;

endpackage

`default_nettype wire

/* src/core_bus_pkg.sv */
// core and bus dimensions
// data, address and select widths, register count and reset pc
`default_nettype none

package core_bus_pkg;

	localparam int xlen = 32;
	// byte address
	localparam int adr_w = 32;
	localparam int sel_w = 4;
	// 32 registers
	localparam int reg_addr_w = 5;
	// first fetch address
	localparam logic [adr_w-1:0] reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire
